/* Bender.yml */
package:
  name: controlPath

export_include_dirs:
  - include

sources:
  - files:
      - source/isaPkg.sv
      - source/ctrlPkg.sv
      - source/instrDecoder.sv
      - source/stageRegs.sv
      - source/forwardUnit.sv
      - source/branchResolver.sv
      - source/controlPath.sv
  - target: test
    files:
      - tests/controlPathTb.sv

/* controlPath.f */
+incdir+include
source/isaPkg.sv
source/ctrlPkg.sv
source/instrDecoder.sv
source/stageRegs.sv
source/forwardUnit.sv
source/branchResolver.sv
source/controlPath.sv
tests/controlPathTb.sv

/* include/ctrl_consts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// Forwarding source selects
`define FWD_NONE 2'd0
`define FWD_WB   2'd1
`define FWD_MEM  2'd2

// Write-back source selects
`define WB_DMEM  2'd0
`define WB_ALU   2'd1
`define WB_PC4   2'd2

// ALU operations
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_AND  4'd2
`define ALU_OR   4'd3
`define ALU_XOR  4'd4
`define ALU_SLL  4'd5
`define ALU_SLT  4'd6
`define ALU_SLTU 4'd7
`define ALU_SRL  4'd8
`define ALU_SRA  4'd9

// Immediate formats for the immediate generator
`define IMM_I    3'd0
`define IMM_S    3'd1
`define IMM_B    3'd2
`define IMM_U    3'd3
`define IMM_J    3'd4

`endif

/* source/branchResolver.sv */
module branchResolver
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  stageInfo_t     memStage,
    input  logic           predictedTaken,
    output branchOutcome_t outcome
);

    logic taken;

    // Condition from the comparator results captured with the branch
    always_comb begin
        case (brFunct3_e'(memStage.funct3))
            BEQ:       taken = memStage.brEq;
            BNE:       taken = !memStage.brEq;
            BLT, BLTU: taken = memStage.brLt;
            BGE, BGEU: taken = !memStage.brLt;
            default:   taken = 1'b0;
        endcase
    end

    always_comb begin
        outcome = '0;
        if (memStage.isJump) begin
            // Always taken, redirect only if fetch missed it
            outcome.pcRedirect = !predictedTaken;
        end else if (memStage.isBranch) begin
            outcome.resolved      = 1'b1;
            outcome.actualTaken   = taken;
            outcome.pcRedirect    = taken != predictedTaken;
            outcome.toFallThrough = predictedTaken && !taken;   // Back to PC + 4
        end
    end

endmodule

/* source/controlPath.sv */
module controlPath
    import ctrlPkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic [31:0]    instr,
    input  logic           brEq,            // For the EX instruction
    input  logic           brLt,
    input  logic           predictedTaken,  // For the MEM instruction
    input  hazardCtl_t     hazard,
    output idCtl_t         idCtl,
    output exCtl_t         exCtl,
    output memCtl_t        memCtl,
    output wbCtl_t         wbCtl,
    output fwdSel_t        fwd,
    output branchOutcome_t outcome
);

    stageInfo_t idInfo;
    stageInfo_t exStage;
    stageInfo_t memStage;
    stageInfo_t wbStage;

    instrDecoder decoder0 (
        .instr  (instr),
        .idInfo (idInfo),
        .idCtl  (idCtl)
    );

    stageRegs stageRegs0 (
        .clk      (clk),
        .reset    (reset),
        .hazard   (hazard),
        .idInfo   (idInfo),
        .brEq     (brEq),
        .brLt     (brLt),
        .exStage  (exStage),
        .memStage (memStage),
        .wbStage  (wbStage)
    );

    forwardUnit forward0 (
        .exStage  (exStage),
        .memStage (memStage),
        .wbStage  (wbStage),
        .fwd      (fwd)
    );

    branchResolver resolver0 (
        .memStage       (memStage),
        .predictedTaken (predictedTaken),
        .outcome        (outcome)
    );

    // ====================
    // Per-stage outputs
    // ====================
    assign exCtl = '{aluSel:       exStage.aluSel,
                     aluASel:      exStage.aluASel,
                     aluBSel:      exStage.aluBSel,
                     branchSigned: exStage.branchSigned,
                     wbSel:        exStage.wbSel};

    assign memCtl = '{funct3: memStage.funct3, dmemWrite: memStage.dmemWrite};

    assign wbCtl = '{regWEn: wbStage.regWEn, wbSel: wbStage.wbSel, rd: wbStage.rd};

endmodule

/* source/ctrlPkg.sv */
package ctrlPkg;

    // ID outputs for fetch and hazard detection
    typedef struct packed {
        logic       jumpEarly;    // JAL target known in ID
        logic       branchEarly;
        logic [2:0] immSel;
        logic       memRead;      // Load in ID, for load-use stalls
        logic [1:0] wbSel;
    } idCtl_t;

    typedef struct packed {
        logic [3:0] aluSel;
        logic       aluASel;      // 0 rs1, 1 PC
        logic       aluBSel;      // 0 rs2, 1 imm
        logic       branchSigned;
        logic [1:0] wbSel;
    } exCtl_t;

    typedef struct packed {
        logic [2:0] funct3;       // Access size and sign
        logic       dmemWrite;
    } memCtl_t;

    typedef struct packed {
        logic       regWEn;
        logic [1:0] wbSel;
        logic [4:0] rd;
    } wbCtl_t;

    // ====================
    // Stage register bundle
    // ====================
    typedef struct packed {
        logic       valid;
        logic       isJump;
        logic       isBranch;
        logic [2:0] funct3;
        logic       regWEn;
        logic [1:0] wbSel;
        logic       dmemWrite;
        logic       branchSigned;
        logic [3:0] aluSel;
        logic       aluASel;
        logic       aluBSel;
        logic       usesRs1;
        logic       usesRs2;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic       brEq;         // Filled on the way into MEM
        logic       brLt;
    } stageInfo_t;

    typedef struct packed {
        logic [1:0] fwdA;
        logic [1:0] fwdB;
        logic [1:0] fwdDmem;
        logic [1:0] fwdBranchA;
        logic [1:0] fwdBranchB;
    } fwdSel_t;

    typedef struct packed {
        logic pcRedirect;
        logic toFallThrough;
        logic resolved;       // Predictor update strobe
        logic actualTaken;
    } branchOutcome_t;

    typedef struct packed {
        logic stall;
        logic flushEx;
        logic flushMem;
    } hazardCtl_t;

endpackage

/* source/forwardUnit.sv */
`include "ctrl_consts.svh"

module forwardUnit
    import ctrlPkg::*;
(
    input  stageInfo_t exStage,
    input  stageInfo_t memStage,
    input  stageInfo_t wbStage,
    output fwdSel_t    fwd
);

    logic [1:0] selRs1;
    logic [1:0] selRs2;

    // Youngest writer wins, x0 never forwards
    function automatic logic [1:0] srcSel(
        input logic       used,
        input logic [4:0] src,
        input stageInfo_t memW,
        input stageInfo_t wbW
    );
        logic [1:0] sel;
        sel = `FWD_NONE;
        if (used && memW.regWEn && memW.rd != 5'd0 && memW.rd == src) begin
            sel = `FWD_MEM;
        end else if (used && wbW.regWEn && wbW.rd != 5'd0 && wbW.rd == src) begin
            sel = `FWD_WB;
        end
        return sel;
    endfunction

    assign selRs1 = srcSel(exStage.usesRs1, exStage.rs1, memStage, wbStage);
    assign selRs2 = srcSel(exStage.usesRs2, exStage.rs2, memStage, wbStage);

    always_comb begin
        fwd = '0;
        if (exStage.isBranch) begin
            // Comparator operands only, the ALU computes the target
            fwd.fwdBranchA = selRs1;
            fwd.fwdBranchB = selRs2;
        end else begin
            fwd.fwdA = selRs1;
            if (exStage.dmemWrite) begin
                fwd.fwdDmem = selRs2;        // Store data
            end else begin
                fwd.fwdB = selRs2;
            end
        end
    end

endmodule

/* source/instrDecoder.sv */
`include "ctrl_consts.svh"

module instrDecoder
    import isaPkg::*;
    import ctrlPkg::*;
(
    input  instrWord_u instr,
    output stageInfo_t idInfo,
    output idCtl_t     idCtl
);

    // funct3 plus the alternate bit (instr[30]) to an ALU operation
    function automatic logic [3:0] aluOp(input logic [2:0] f3, input logic alt);
        logic [3:0] op;
        case (f3)
            F3_ADD:  op = alt ? `ALU_SUB : `ALU_ADD;
            F3_SLL:  op = `ALU_SLL;
            F3_SLT:  op = `ALU_SLT;
            F3_SLTU: op = `ALU_SLTU;
            F3_XOR:  op = `ALU_XOR;
            F3_SR:   op = alt ? `ALU_SRA : `ALU_SRL;
            F3_OR:   op = `ALU_OR;
            default: op = `ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        idInfo        = '0;
        idInfo.rd     = instr.rType.rd;
        idInfo.wbSel  = `WB_ALU;
        idInfo.aluSel = `ALU_ADD;
        idCtl         = '0;
        idCtl.immSel  = `IMM_I;

        case (instr.rType.opcode)
            OP: begin
                idInfo.valid   = 1'b1;
                idInfo.regWEn  = 1'b1;
                idInfo.funct3  = instr.rType.funct3;
                idInfo.rs1     = instr.rType.rs1;
                idInfo.rs2     = instr.rType.rs2;
                idInfo.usesRs1 = 1'b1;
                idInfo.usesRs2 = 1'b1;
                idInfo.aluSel  = aluOp(instr.rType.funct3, instr.rType.funct7[5]);
            end
            OP_IMM: begin
                idInfo.valid   = 1'b1;
                idInfo.regWEn  = 1'b1;
                idInfo.funct3  = instr.iType.funct3;
                idInfo.rs1     = instr.iType.rs1;
                idInfo.usesRs1 = 1'b1;
                idInfo.aluBSel = 1'b1;
                // No SUBI, so only the shifts look at bit 30
                idInfo.aluSel  = aluOp(instr.iType.funct3,
                                       instr.iType.funct3 == F3_SR && instr.iType.imm[10]);
            end
            LOAD: begin
                idInfo.valid   = 1'b1;
                idInfo.regWEn  = 1'b1;
                idInfo.funct3  = instr.iType.funct3;
                idInfo.rs1     = instr.iType.rs1;
                idInfo.usesRs1 = 1'b1;
                idInfo.aluBSel = 1'b1;           // Address = rs1 + imm
                idInfo.wbSel   = `WB_DMEM;
                idCtl.memRead  = 1'b1;
            end
            STORE: begin
                idInfo.valid     = 1'b1;
                idInfo.funct3    = instr.sType.funct3;
                idInfo.rs1       = instr.sType.rs1;
                idInfo.rs2       = instr.sType.rs2;
                idInfo.usesRs1   = 1'b1;
                idInfo.usesRs2   = 1'b1;
                idInfo.aluBSel   = 1'b1;
                idInfo.dmemWrite = 1'b1;
                idCtl.immSel     = `IMM_S;
            end
            BRANCH: begin
                idInfo.valid        = 1'b1;
                idInfo.isBranch     = 1'b1;
                idInfo.funct3       = instr.bType.funct3;
                idInfo.rs1          = instr.bType.rs1;
                idInfo.rs2          = instr.bType.rs2;
                idInfo.usesRs1      = 1'b1;
                idInfo.usesRs2      = 1'b1;
                idInfo.aluASel      = 1'b1;      // ALU forms the target PC + imm
                idInfo.aluBSel      = 1'b1;
                idInfo.branchSigned = instr.bType.funct3 == BLT || instr.bType.funct3 == BGE;
                idCtl.immSel        = `IMM_B;
            end
            JAL: begin
                idInfo.valid    = 1'b1;
                idInfo.isJump   = 1'b1;
                idInfo.regWEn   = 1'b1;
                idInfo.aluASel  = 1'b1;
                idInfo.aluBSel  = 1'b1;
                idInfo.wbSel    = `WB_PC4;
                idCtl.immSel    = `IMM_J;
                idCtl.jumpEarly = 1'b1;
            end
            JALR: begin
                idInfo.valid   = 1'b1;
                idInfo.isJump  = 1'b1;
                idInfo.regWEn  = 1'b1;
                idInfo.funct3  = instr.iType.funct3;
                idInfo.rs1     = instr.iType.rs1;
                idInfo.usesRs1 = 1'b1;
                idInfo.aluBSel = 1'b1;
                idInfo.wbSel   = `WB_PC4;
            end
            LUI: begin
                // rs1 left at x0 so operand A reads as zero
                idInfo.valid   = 1'b1;
                idInfo.regWEn  = 1'b1;
                idInfo.aluBSel = 1'b1;
                idCtl.immSel   = `IMM_U;
            end
            AUIPC: begin
                idInfo.valid   = 1'b1;
                idInfo.regWEn  = 1'b1;
                idInfo.aluASel = 1'b1;
                idInfo.aluBSel = 1'b1;
                idCtl.immSel   = `IMM_U;
            end
            default: ;                          // Unknown opcode decodes to a bubble
        endcase

        // Writes to x0 are dropped here
        if (idInfo.rd == 5'd0) begin
            idInfo.regWEn = 1'b0;
        end

        idCtl.branchEarly = idInfo.isBranch;
        idCtl.wbSel       = idInfo.wbSel;
    end

endmodule

/* source/isaPkg.sv */
package isaPkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } brFunct3_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,  // ADD or SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // SRL or SRA
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } aluFunct3_e;

    // ====================
    // Instruction formats
    // ====================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcode_e    opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcode_e    opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } uType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        opcode_e    opcode;
    } jType_t;

    // One word, six ways of reading it
    typedef union packed {
        rType_t rType;
        iType_t iType;
        sType_t sType;
        bType_t bType;
        uType_t uType;
        jType_t jType;
    } instrWord_u;

endpackage

/* source/stageRegs.sv */
module stageRegs
    import ctrlPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  hazardCtl_t hazard,
    input  stageInfo_t idInfo,
    input  logic       brEq,
    input  logic       brLt,
    output stageInfo_t exStage,
    output stageInfo_t memStage,
    output stageInfo_t wbStage
);

    localparam stageInfo_t BUBBLE = '0;

    stageInfo_t exToMem;

    // Comparator results belong to the EX instruction
    always_comb begin
        exToMem      = exStage;
        exToMem.brEq = brEq;
        exToMem.brLt = brLt;
    end

    // ====================
    // ID/EX
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            exStage <= BUBBLE;
        end else if (hazard.flushEx) begin
            exStage <= BUBBLE;               // Flush wins over stall
        end else if (!hazard.stall) begin
            exStage <= idInfo;
        end
    end

    // ====================
    // EX/MEM and MEM/WB
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            memStage <= BUBBLE;
            wbStage  <= BUBBLE;
        end else begin
            // EX instruction stays put on a stall, so MEM gets a hole
            if (hazard.stall || hazard.flushMem) begin
                memStage <= BUBBLE;
            end else begin
                memStage <= exToMem;
            end
            wbStage <= memStage;             // Never held
        end
    end

endmodule

/* tests/controlPathTb.sv */
`include "ctrl_consts.svh"

module controlPathTb
    import isaPkg::*;
    import ctrlPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 20;
    localparam logic [31:0] NOP = 32'h0000_0013;    // addi x0, x0, 0
    localparam hazardCtl_t NO_HZ = '0;

    // Upper bounds on the cycles each test spends
    localparam int RESET_CYCLES  = 8;
    localparam int DECODE_CYCLES = 14;
    localparam int FWD_CYCLES    = 20;
    localparam int BRANCH_CYCLES = 160;
    localparam int HAZARD_CYCLES = 20;
    localparam int RANDOM_CYCLES = 404;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + DECODE_CYCLES + FWD_CYCLES
                                 + BRANCH_CYCLES + HAZARD_CYCLES + RANDOM_CYCLES;

    logic           clk;
    logic           reset;
    logic [31:0]    instr;
    logic           brEq;
    logic           brLt;
    logic           predictedTaken;
    hazardCtl_t     hazard;
    idCtl_t         idCtl;
    exCtl_t         exCtl;
    memCtl_t        memCtl;
    wbCtl_t         wbCtl;
    fwdSel_t        fwd;
    branchOutcome_t outcome;

    // Model of the three stage registers
    stageInfo_t exM;
    stageInfo_t memM;
    stageInfo_t wbM;

    int          errors = 0;
    int          passes = 0;
    logic [31:0] lfsrState = 32'h59fe_bff9;
    logic [6:0]  opTab [9];

    controlPath dut0 (
        .clk            (clk),
        .reset          (reset),
        .instr          (instr),
        .brEq           (brEq),
        .brLt           (brLt),
        .predictedTaken (predictedTaken),
        .hazard         (hazard),
        .idCtl          (idCtl),
        .exCtl          (exCtl),
        .memCtl         (memCtl),
        .wbCtl          (wbCtl),
        .fwd            (fwd),
        .outcome        (outcome)
    );

    always #(HALF_PERIOD) clk = ~clk;

    // ====================
    // Random source
    // ====================
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v[i] = lfsrState[0];
        end
        return v;
    endfunction

    // ====================
    // Reference model
    // ====================
    function automatic logic [3:0] aluRef(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? `ALU_SUB : `ALU_ADD;
            3'd1:    return `ALU_SLL;
            3'd2:    return `ALU_SLT;
            3'd3:    return `ALU_SLTU;
            3'd4:    return `ALU_XOR;
            3'd5:    return alt ? `ALU_SRA : `ALU_SRL;
            3'd6:    return `ALU_OR;
            default: return `ALU_AND;
        endcase
    endfunction

    function automatic void decodeRef(input logic [31:0] w, output stageInfo_t info,
                                      output idCtl_t ctl);
        logic [2:0] f3;
        f3 = w[14:12];
        info = '0;
        info.rd = w[11:7];
        info.wbSel = `WB_ALU;
        info.aluSel = `ALU_ADD;
        ctl = '0;
        ctl.immSel = `IMM_I;
        info.valid = 1'b1;
        case (w[6:0])
            OP: begin
                info.regWEn = 1'b1;
                info.funct3 = f3;
                info.rs1 = w[19:15];
                info.rs2 = w[24:20];
                info.usesRs1 = 1'b1;
                info.usesRs2 = 1'b1;
                info.aluSel = aluRef(f3, w[30]);
            end
            OP_IMM: begin
                info.regWEn = 1'b1;
                info.funct3 = f3;
                info.rs1 = w[19:15];
                info.usesRs1 = 1'b1;
                info.aluBSel = 1'b1;
                info.aluSel = aluRef(f3, f3 == 3'd5 && w[30]);   // Only SRAI uses bit 30
            end
            LOAD: begin
                info.regWEn = 1'b1;
                info.funct3 = f3;
                info.rs1 = w[19:15];
                info.usesRs1 = 1'b1;
                info.aluBSel = 1'b1;
                info.wbSel = `WB_DMEM;
                ctl.memRead = 1'b1;
            end
            STORE: begin
                info.funct3 = f3;
                info.rs1 = w[19:15];
                info.rs2 = w[24:20];
                info.usesRs1 = 1'b1;
                info.usesRs2 = 1'b1;
                info.aluBSel = 1'b1;
                info.dmemWrite = 1'b1;
                ctl.immSel = `IMM_S;
            end
            BRANCH: begin
                info.isBranch = 1'b1;
                info.funct3 = f3;
                info.rs1 = w[19:15];
                info.rs2 = w[24:20];
                info.usesRs1 = 1'b1;
                info.usesRs2 = 1'b1;
                info.aluASel = 1'b1;
                info.aluBSel = 1'b1;
                info.branchSigned = (f3 == 3'b100) || (f3 == 3'b101);
                ctl.immSel = `IMM_B;
            end
            JAL: begin
                info.isJump = 1'b1;
                info.regWEn = 1'b1;
                info.aluASel = 1'b1;
                info.aluBSel = 1'b1;
                info.wbSel = `WB_PC4;
                ctl.immSel = `IMM_J;
                ctl.jumpEarly = 1'b1;
            end
            JALR: begin
                info.isJump = 1'b1;
                info.regWEn = 1'b1;
                info.funct3 = f3;
                info.rs1 = w[19:15];
                info.usesRs1 = 1'b1;
                info.aluBSel = 1'b1;
                info.wbSel = `WB_PC4;
            end
            LUI: begin
                info.regWEn = 1'b1;
                info.aluBSel = 1'b1;
                ctl.immSel = `IMM_U;
            end
            AUIPC: begin
                info.regWEn = 1'b1;
                info.aluASel = 1'b1;
                info.aluBSel = 1'b1;
                ctl.immSel = `IMM_U;
            end
            default: info.valid = 1'b0;
        endcase
        if (info.rd == 5'd0) info.regWEn = 1'b0;
        ctl.branchEarly = info.isBranch;
        ctl.wbSel = info.wbSel;
    endfunction

    function automatic logic [1:0] matchRef(input logic used, input logic [4:0] src,
                                            input stageInfo_t m, input stageInfo_t w);
        if (!used || src == 5'd0) return `FWD_NONE;
        if (m.regWEn && m.rd == src) return `FWD_MEM;
        if (w.regWEn && w.rd == src) return `FWD_WB;
        return `FWD_NONE;
    endfunction

    function automatic fwdSel_t forwardRef(input stageInfo_t e, input stageInfo_t m,
                                           input stageInfo_t w);
        fwdSel_t f;
        logic [1:0] a;
        logic [1:0] b;
        f = '0;
        a = matchRef(e.usesRs1, e.rs1, m, w);
        b = matchRef(e.usesRs2, e.rs2, m, w);
        if (e.isBranch) begin
            f.fwdBranchA = a;
            f.fwdBranchB = b;
        end else begin
            f.fwdA = a;
            if (e.dmemWrite) f.fwdDmem = b;
            else f.fwdB = b;
        end
        return f;
    endfunction

    function automatic branchOutcome_t resolveRef(input stageInfo_t m, input logic pred);
        branchOutcome_t o;
        logic t;
        o = '0;
        case (m.funct3)
            3'b000:         t = m.brEq;
            3'b001:         t = !m.brEq;
            3'b100, 3'b110: t = m.brLt;
            3'b101, 3'b111: t = !m.brLt;
            default:        t = 1'b0;
        endcase
        if (m.isJump) begin
            o.pcRedirect = !pred;
        end else if (m.isBranch) begin
            o.resolved = 1'b1;
            o.actualTaken = t;
            o.pcRedirect = t != pred;
            o.toFallThrough = pred && !t;
        end
        return o;
    endfunction

    // Stage model, oldest stage first
    always @(posedge clk) begin
        stageInfo_t idM;
        idCtl_t     unused;
        decodeRef(instr, idM, unused);
        if (reset) begin
            exM = '0;
            memM = '0;
            wbM = '0;
        end else begin
            wbM = memM;
            if (hazard.stall || hazard.flushMem) begin
                memM = '0;
            end else begin
                memM = exM;
                memM.brEq = brEq;
                memM.brLt = brLt;
            end
            if (hazard.flushEx) exM = '0;
            else if (!hazard.stall) exM = idM;
        end
    end

    // ====================
    // Comparing process
    // ====================
    task automatic checkField(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp) begin
            passes++;
        end else begin
            errors++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    initial begin
        stageInfo_t idE;
        idCtl_t     idCtlE;
        forever begin
            @(posedge clk);
            #(2 * HALF_PERIOD - 2);                      // Just before the next edge
            decodeRef(instr, idE, idCtlE);
            checkField("idCtl", idCtl, idCtlE);
            checkField("exCtl", exCtl, {exM.aluSel, exM.aluASel, exM.aluBSel,
                                        exM.branchSigned, exM.wbSel});
            checkField("memCtl", memCtl, {memM.funct3, memM.dmemWrite});
            checkField("wbCtl", wbCtl, {wbM.regWEn, wbM.wbSel, wbM.rd});
            checkField("fwd", fwd, forwardRef(exM, memM, wbM));
            checkField("outcome", outcome, resolveRef(memM, predictedTaken));
        end
    end

    // ====================
    // Stimulus helpers
    // ====================
    function automatic logic [31:0] rWord(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] iWord(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {12'h404, rs1, f3, rd, op};
    endfunction

    // Low immediate bits sit where rd would be, here a copy of rs2
    function automatic logic [31:0] sbWord(input logic [6:0] op, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3);
        return {7'd0, rs2, rs1, f3, rs2, op};
    endfunction

    task automatic step(input logic [31:0] w, input hazardCtl_t hz, input logic eq,
                        input logic lt, input logic pred);
        @(posedge clk);
        #2;
        instr = w;
        hazard = hz;
        brEq = eq;
        brLt = lt;
        predictedTaken = pred;
    endtask

    task automatic drain();
        repeat (4) step(NOP, NO_HZ, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        $display("%-14s done, %0d errors", name, errors - startErrors);
    endtask

    // ====================
    // Tests
    // ====================
    initial begin
        int         e0;
        hazardCtl_t hz;
        logic [2:0] brF3 [6];
        brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        opTab = '{LOAD, STORE, OP, OP_IMM, BRANCH, JAL, JALR, LUI, AUIPC};
        clk = 1'b0;
        reset = 1'b1;
        instr = rWord(1'b0, 5'd2, 5'd1, 3'd0, 5'd3);    // Real work held off by reset
        hazard = NO_HZ;
        brEq = 1'b1;
        brLt = 1'b1;
        predictedTaken = 1'b1;

        // Reset state
        e0 = errors;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        step(NOP, NO_HZ, 1'b0, 1'b0, 1'b1);
        step(NOP, NO_HZ, 1'b0, 1'b0, 1'b0);
        reportTest("reset", e0);

        // One of each opcode class, then let it run out
        e0 = errors;
        step(iWord(LOAD, 5'd1, 5'd2, 3'd2), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(sbWord(STORE, 5'd3, 5'd4, 3'd2), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(rWord(1'b1, 5'd5, 5'd6, 3'd0, 5'd7), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(iWord(OP_IMM, 5'd8, 5'd9, 3'd5), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(sbWord(BRANCH, 5'd1, 5'd2, 3'd4), NO_HZ, 1'b0, 1'b0, 1'b0);
        step({20'h00010, 5'd1, JAL}, NO_HZ, 1'b0, 1'b0, 1'b0);
        step(iWord(JALR, 5'd0, 5'd1, 3'd0), NO_HZ, 1'b0, 1'b0, 1'b0);
        step({20'h12345, 5'd10, LUI}, NO_HZ, 1'b0, 1'b0, 1'b0);
        step({20'h00abc, 5'd11, AUIPC}, NO_HZ, 1'b0, 1'b0, 1'b0);
        drain();
        reportTest("decode", e0);

        // Dependent sequences
        e0 = errors;
        step(rWord(1'b0, 5'd1, 5'd1, 3'd0, 5'd5), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(rWord(1'b0, 5'd2, 5'd2, 3'd0, 5'd5), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(rWord(1'b0, 5'd5, 5'd5, 3'd0, 5'd6), NO_HZ, 1'b0, 1'b0, 1'b0);  // MEM wins
        step(rWord(1'b0, 5'd0, 5'd0, 3'd0, 5'd0), NO_HZ, 1'b0, 1'b0, 1'b0);  // x0 writer
        step(rWord(1'b0, 5'd0, 5'd0, 3'd0, 5'd7), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(sbWord(STORE, 5'd6, 5'd7, 3'd2), NO_HZ, 1'b0, 1'b0, 1'b0);      // Non-writer
        step(sbWord(STORE, 5'd7, 5'd6, 3'd2), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(iWord(LOAD, 5'd8, 5'd6, 3'd2), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(sbWord(BRANCH, 5'd8, 5'd6, 3'd0), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(sbWord(BRANCH, 5'd8, 5'd8, 3'd1), NO_HZ, 1'b0, 1'b0, 1'b0);
        drain();
        reportTest("forwarding", e0);

        // Every branch condition against both comparator bits and the guess
        e0 = errors;
        for (int f = 0; f < 6; f++) begin
            for (int k = 0; k < 8; k++) begin
                step(sbWord(BRANCH, 5'd1, 5'd2, brF3[f]), NO_HZ, 1'b0, 1'b0, 1'b0);
                step(NOP, NO_HZ, k[0], k[1], 1'b0);
                step(NOP, NO_HZ, 1'b0, 1'b0, k[2]);
            end
        end
        for (int k = 0; k < 4; k++) begin
            step(k[1] ? iWord(JALR, 5'd1, 5'd2, 3'd0) : {20'h0, 5'd1, JAL},
                 NO_HZ, 1'b0, 1'b0, 1'b0);
            step(NOP, NO_HZ, 1'b1, 1'b1, 1'b0);
            step(NOP, NO_HZ, 1'b0, 1'b0, k[0]);
        end
        drain();
        reportTest("branch", e0);

        // Flushes and a stall
        e0 = errors;
        step(rWord(1'b0, 5'd1, 5'd2, 3'd0, 5'd3), NO_HZ, 1'b0, 1'b0, 1'b0);
        hz = '{stall: 1'b0, flushEx: 1'b1, flushMem: 1'b0};
        step(rWord(1'b0, 5'd3, 5'd3, 3'd7, 5'd4), hz, 1'b0, 1'b0, 1'b0);
        hz = '{stall: 1'b0, flushEx: 1'b0, flushMem: 1'b1};
        step(sbWord(STORE, 5'd4, 5'd3, 3'd2), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(NOP, hz, 1'b0, 1'b0, 1'b0);
        step(iWord(LOAD, 5'd9, 5'd3, 3'd0), NO_HZ, 1'b0, 1'b0, 1'b0);
        hz = '{stall: 1'b1, flushEx: 1'b0, flushMem: 1'b0};
        step(rWord(1'b0, 5'd9, 5'd9, 3'd0, 5'd10), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(rWord(1'b0, 5'd10, 5'd9, 3'd4, 5'd11), hz, 1'b0, 1'b0, 1'b0);  // Load-use hold
        step(rWord(1'b0, 5'd10, 5'd9, 3'd4, 5'd11), hz, 1'b0, 1'b0, 1'b0);
        step(rWord(1'b0, 5'd10, 5'd9, 3'd4, 5'd11), NO_HZ, 1'b0, 1'b0, 1'b0);
        step(sbWord(BRANCH, 5'd9, 5'd10, 3'd0), NO_HZ, 1'b1, 1'b0, 1'b0);
        drain();
        reportTest("hazard", e0);

        // Random stream over a small register set to make collisions likely
        e0 = errors;
        for (int n = 0; n < 400; n++) begin
            logic [6:0]  op;
            logic [31:0] w;
            logic [31:0] b;
            op = opTab[takeBits(4) % 9];
            b = takeBits(13);
            w = {1'b0, b[0], 5'd0, 2'b00, b[3:1], 2'b00, b[6:4],
                 b[9:7], 2'b00, b[12:10], op};
            b = takeBits(12);
            hz.stall = b[2:0] == 3'd0;
            hz.flushEx = b[5:3] == 3'd0;
            hz.flushMem = b[8:6] == 3'd0;
            step(w, hz, b[9], b[10], b[11]);
        end
        drain();
        reportTest("random", e0);

        @(posedge clk);
        $display("Checks passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TOTAL_CYCLES + 20) * 2 * HALF_PERIOD);
        $display("Run timed out before all tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
